// File: source/mbus_pkg.sv
package mbus_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// start bit, then address and data msb first, then the ack slot
	localparam int PAYLOAD_BITS = ADDR_W + DATA_W;
	localparam int FRAME_BITS = 1 + PAYLOAD_BITS + 1;
	localparam int ACK_POS = FRAME_BITS - 1;

	// every member takes this one
	localparam logic [ADDR_W-1:0] BCAST_ADDR = '1;

	// where a member's snoop sits inside the frame
	typedef enum logic [1:0]
	{
		idle,
		addr,
		data,
		ack
	} snoop_state_e;

	// wake runs through the three staged states
	typedef enum logic [2:0]
	{
		awake,
		asleep,
		wake_clk,
		wake_rst,
		wake_iso
	} power_state_e;

endpackage

// File: source/mbus_frame_tx.sv
module mbus_frame_tx
	import mbus_pkg::*;
#(
	parameter int TX_DEPTH = 2
)(
	input  logic              clkin,
	input  logic              rst_n,
	input  logic              tx_valid,
	input  logic [ADDR_W-1:0] tx_addr,
	input  logic [DATA_W-1:0] tx_data,
	output logic              tx_credit,
	input  logic              ring_free,
	output logic              ser_out
);

	localparam int PTR_W = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
	localparam int CNT_W = $clog2(TX_DEPTH + 1);
	localparam int SH_W = FRAME_BITS - 1;
	localparam int BIT_W = $clog2(FRAME_BITS);

	logic [PAYLOAD_BITS-1:0] mem [TX_DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [CNT_W-1:0]        count;
	logic                    ring_busy;
	logic                    launch;
	logic [SH_W-1:0]         shift_q;
	logic [BIT_W-1:0]        bits_left;

	// one frame on the ring at a time
	assign launch = !ring_busy && (count != '0);

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			ring_busy <= 1'b0;
			bits_left <= '0;
			ser_out   <= 1'b0;
			tx_credit <= 1'b0;
		end
		else
		begin
			tx_credit <= launch;
			count     <= count + CNT_W'(tx_valid) - CNT_W'(launch);
			if (tx_valid)
				wr_ptr <= (wr_ptr == PTR_W'(TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (launch)
			begin
				rd_ptr    <= (rd_ptr == PTR_W'(TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				ring_busy <= 1'b1;
				bits_left <= BIT_W'(SH_W);
				// start bit
				ser_out   <= 1'b1;
			end
			else
			begin
				if (ring_free)
					ring_busy <= 1'b0;
				if (bits_left != '0)
				begin
					ser_out   <= shift_q[SH_W-1];
					bits_left <= bits_left - 1'b1;
				end
				else
					ser_out <= 1'b0;
			end
		end
	end

	always_ff @(posedge clkin)
	begin
		if (tx_valid)
			mem[wr_ptr] <= {tx_addr, tx_data};
		// ack slot always leaves as 0
		if (launch)
			shift_q <= {mem[rd_ptr], 1'b0};
		else
			shift_q <= {shift_q[SH_W-2:0], 1'b0};
	end

endmodule

// File: source/mbus_frame_snoop.sv
module mbus_frame_snoop
	import mbus_pkg::*;
#(
	parameter logic [ADDR_W-1:0] NODE_ADDR = 8'h10
)(
	input  logic              clkin,
	input  logic              rst_n,
	input  logic              ser_in,
	output logic              ser_out,
	input  logic              accept_ok,
	output logic              rx_write,
	output logic [DATA_W-1:0] rx_word,
	output logic              rx_is_bcast,
	output logic              wake_hit,
	output logic              busy
);

	localparam int CNT_W = $clog2(DATA_W);
	localparam logic [CNT_W-1:0] ADDR_LAST = CNT_W'(ADDR_W - 1);
	localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(DATA_W - 1);

	snoop_state_e      state;
	logic [CNT_W-1:0]  bit_cnt;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] data_q;
	logic              uni_hit;
	logic              bc_hit;
	logic              take;

	// address is complete once the data bits start
	assign uni_hit = (addr_q == NODE_ADDR);
	assign bc_hit  = (addr_q == BCAST_ADDR);

	// in the ack state ser_in carries the ack slot
	assign take     = (state == ack) && (uni_hit || bc_hit) && accept_ok;
	assign wake_hit = (state == ack) && uni_hit && !accept_ok;
	assign busy     = (state != idle);

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= idle;
			bit_cnt  <= '0;
			ser_out  <= 1'b0;
			rx_write <= 1'b0;
		end
		else
		begin
			// one register per hop with the ack ORed in on the way through
			ser_out  <= ser_in | take;
			rx_write <= take;
			case (state)
				idle:
				begin
					if (ser_in)
					begin
						state   <= addr;
						bit_cnt <= '0;
					end
				end
				addr:
				begin
					if (bit_cnt == ADDR_LAST)
					begin
						state   <= data;
						bit_cnt <= '0;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				data:
				begin
					if (bit_cnt == DATA_LAST)
						state <= ack;
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				ack:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clkin)
	begin
		if (state == addr)
			addr_q <= {addr_q[ADDR_W-2:0], ser_in};
		if (state == data)
			data_q <= {data_q[DATA_W-2:0], ser_in};
		if (take)
		begin
			rx_word     <= data_q;
			rx_is_bcast <= bc_hit;
		end
	end

endmodule

// File: source/mbus_sleep_ctrl.sv
module mbus_sleep_ctrl
	import mbus_pkg::*;
(
	input  logic clkin,
	input  logic rst_n,
	input  logic lc_sleep,
	input  logic wake_hit,
	input  logic busy,
	output logic lc_power_on,
	output logic lc_release_clk,
	output logic lc_release_rst,
	output logic lc_release_iso
);

	power_state_e state;
	logic         sleep_pend;
	logic         sleep_req;

	assign sleep_req = lc_sleep | sleep_pend;

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= awake;
			sleep_pend <= 1'b0;
		end
		else
		begin
			// hold the request across a frame in flight
			sleep_pend <= (state == awake) && sleep_req && busy;
			case (state)
				awake:
				begin
					if (sleep_req && !busy)
						state <= asleep;
				end
				asleep:
				begin
					if (wake_hit)
						state <= wake_clk;
				end
				wake_clk:
					state <= wake_rst;
				wake_rst:
					state <= wake_iso;
				wake_iso:
					state <= awake;
				default:
					state <= awake;
			endcase
		end
	end

	// stages release power, clock, reset, isolation in that order
	assign lc_power_on    = (state != asleep);
	assign lc_release_clk = (state == awake) || (state == wake_rst) || (state == wake_iso);
	assign lc_release_rst = (state == awake) || (state == wake_iso);
	assign lc_release_iso = (state == awake);

endmodule

// File: source/mbus_rx_buffer.sv
module mbus_rx_buffer
	import mbus_pkg::*;
#(
	parameter int RX_DEPTH   = 2,
	parameter int LC_CREDITS = 2
)(
	input  logic              clkin,
	input  logic              rst_n,
	input  logic              rx_write,
	input  logic [DATA_W-1:0] rx_word,
	input  logic              rx_is_bcast,
	input  logic              deliver_en,
	input  logic              rx_credit,
	output logic              has_space,
	output logic              rx_valid,
	output logic [DATA_W-1:0] rx_data,
	output logic              rx_bcast
);

	localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
	localparam int CNT_W = $clog2(RX_DEPTH + 1);
	localparam int CRD_W = $clog2(LC_CREDITS + 1);

	// broadcast flag kept in the top bit
	logic [DATA_W:0]  mem [RX_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic             pop;

	assign has_space = (count != CNT_W'(RX_DEPTH));
	assign pop       = deliver_en && (count != '0) && (credits != '0);

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credits  <= CRD_W'(LC_CREDITS);
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= pop;
			count    <= count + CNT_W'(rx_write) - CNT_W'(pop);
			credits  <= credits + CRD_W'(rx_credit) - CRD_W'(pop);
			if (rx_write)
				wr_ptr <= (wr_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clkin)
	begin
		if (rx_write)
			mem[wr_ptr] <= {rx_is_bcast, rx_word};
		if (pop)
			{rx_bcast, rx_data} <= mem[rd_ptr];
	end

endmodule

// File: source/mbus_member_layer.sv
module mbus_member_layer
	import mbus_pkg::*;
#(
	parameter logic [ADDR_W-1:0] NODE_ADDR  = 8'h10,
	parameter int                RX_DEPTH   = 2,
	parameter int                LC_CREDITS = 2
)(
	input  logic              clkin,
	input  logic              rst_n,
	input  logic              ser_in,
	output logic              ser_out,
	output logic              rx_valid,
	output logic [DATA_W-1:0] rx_data,
	output logic              rx_bcast,
	input  logic              rx_credit,
	input  logic              lc_sleep,
	output logic              lc_power_on,
	output logic              lc_release_clk,
	output logic              lc_release_rst,
	output logic              lc_release_iso
);

	logic              rx_write;
	logic [DATA_W-1:0] rx_word;
	logic              rx_is_bcast;
	logic              wake_hit;
	logic              busy;
	logic              has_space;
	logic              accept_ok;
	logic              deliver_en;

	// a powered down layer neither accepts nor receives
	assign accept_ok  = lc_release_iso & has_space;
	assign deliver_en = lc_release_iso;

	// wire path and frame tracking stay on while asleep
	mbus_frame_snoop #(
		.NODE_ADDR (NODE_ADDR)
	) u_snoop (
		.clkin       (clkin),
		.rst_n       (rst_n),
		.ser_in      (ser_in),
		.ser_out     (ser_out),
		.accept_ok   (accept_ok),
		.rx_write    (rx_write),
		.rx_word     (rx_word),
		.rx_is_bcast (rx_is_bcast),
		.wake_hit    (wake_hit),
		.busy        (busy)
	);

	mbus_sleep_ctrl u_sleep (
		.clkin          (clkin),
		.rst_n          (rst_n),
		.lc_sleep       (lc_sleep),
		.wake_hit       (wake_hit),
		.busy           (busy),
		.lc_power_on    (lc_power_on),
		.lc_release_clk (lc_release_clk),
		.lc_release_rst (lc_release_rst),
		.lc_release_iso (lc_release_iso)
	);

	mbus_rx_buffer #(
		.RX_DEPTH   (RX_DEPTH),
		.LC_CREDITS (LC_CREDITS)
	) u_rxbuf (
		.clkin       (clkin),
		.rst_n       (rst_n),
		.rx_write    (rx_write),
		.rx_word     (rx_word),
		.rx_is_bcast (rx_is_bcast),
		.deliver_en  (deliver_en),
		.rx_credit   (rx_credit),
		.has_space   (has_space),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.rx_bcast    (rx_bcast)
	);

endmodule

// File: source/mbus_frame_sink.sv
module mbus_frame_sink
	import mbus_pkg::*;
#(
	parameter int NUM_NODES = 4
)(
	input  logic clkin,
	input  logic rst_n,
	input  logic ser_in,
	output logic tx_succ,
	output logic tx_fail,
	output logic ring_free
);

	localparam int CNT_W = $clog2(FRAME_BITS);
	localparam int GRD_W = $clog2(NUM_NODES + 1);

	logic             line_q;
	logic             in_frame;
	logic [CNT_W-1:0] bit_cnt;
	logic [GRD_W-1:0] guard;

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			line_q    <= 1'b0;
			in_frame  <= 1'b0;
			bit_cnt   <= '0;
			guard     <= '0;
			tx_succ   <= 1'b0;
			tx_fail   <= 1'b0;
			ring_free <= 1'b0;
		end
		else
		begin
			line_q    <= ser_in;
			tx_succ   <= 1'b0;
			tx_fail   <= 1'b0;
			ring_free <= 1'b0;
			if (in_frame)
			begin
				if (bit_cnt == CNT_W'(ACK_POS))
				begin
					in_frame  <= 1'b0;
					tx_succ   <= line_q;
					tx_fail   <= !line_q;
					ring_free <= 1'b1;
					// next frame needs at least a full ring pass to get here
					guard     <= GRD_W'(NUM_NODES);
				end
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
			else if (guard != '0)
				guard <= guard - 1'b1;
			else if (line_q)
			begin
				in_frame <= 1'b1;
				bit_cnt  <= CNT_W'(1);
			end
		end
	end

endmodule

// File: source/mbus_ring_top.sv
module mbus_ring_top
	import mbus_pkg::*;
#(
	parameter int                NUM_NODES  = 4,
	parameter logic [ADDR_W-1:0] BASE_ADDR  = 8'h10,
	parameter int                TX_DEPTH   = 2,
	parameter int                RX_DEPTH   = 2,
	parameter int                LC_CREDITS = 2
)(
	input  logic                        clkin,
	input  logic                        rst_n,
	input  logic                        tx_valid,
	input  logic [ADDR_W-1:0]           tx_addr,
	input  logic [DATA_W-1:0]           tx_data,
	output logic                        tx_credit,
	output logic                        tx_succ,
	output logic                        tx_fail,
	output logic [NUM_NODES-1:0]        rx_valid,
	output logic [NUM_NODES*DATA_W-1:0] rx_data,
	output logic [NUM_NODES-1:0]        rx_bcast,
	input  logic [NUM_NODES-1:0]        rx_credit,
	input  logic [NUM_NODES-1:0]        lc_sleep,
	output logic [NUM_NODES-1:0]        lc_power_on,
	output logic [NUM_NODES-1:0]        lc_release_clk,
	output logic [NUM_NODES-1:0]        lc_release_rst,
	output logic [NUM_NODES-1:0]        lc_release_iso
);

	// ring[0] from the injector, ring[NUM_NODES] into the sink
	logic [NUM_NODES:0] ring;
	logic               ring_free;

	mbus_frame_tx #(
		.TX_DEPTH (TX_DEPTH)
	) u_tx (
		.clkin     (clkin),
		.rst_n     (rst_n),
		.tx_valid  (tx_valid),
		.tx_addr   (tx_addr),
		.tx_data   (tx_data),
		.tx_credit (tx_credit),
		.ring_free (ring_free),
		.ser_out   (ring[0])
	);

	for (genvar i = 0; i < NUM_NODES; i++)
	begin : g_member
		mbus_member_layer #(
			.NODE_ADDR  (ADDR_W'(BASE_ADDR + i)),
			.RX_DEPTH   (RX_DEPTH),
			.LC_CREDITS (LC_CREDITS)
		) u_member (
			.clkin          (clkin),
			.rst_n          (rst_n),
			.ser_in         (ring[i]),
			.ser_out        (ring[i+1]),
			.rx_valid       (rx_valid[i]),
			.rx_data        (rx_data[i*DATA_W +: DATA_W]),
			.rx_bcast       (rx_bcast[i]),
			.rx_credit      (rx_credit[i]),
			.lc_sleep       (lc_sleep[i]),
			.lc_power_on    (lc_power_on[i]),
			.lc_release_clk (lc_release_clk[i]),
			.lc_release_rst (lc_release_rst[i]),
			.lc_release_iso (lc_release_iso[i])
		);
	end

	mbus_frame_sink #(
		.NUM_NODES (NUM_NODES)
	) u_sink (
		.clkin     (clkin),
		.rst_n     (rst_n),
		.ser_in    (ring[NUM_NODES]),
		.tx_succ   (tx_succ),
		.tx_fail   (tx_fail),
		.ring_free (ring_free)
	);

endmodule

// File: tb/mbus_ring_tb.sv
module mbus_ring_tb
	import mbus_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int                NUM_NODES  = 4;
	localparam logic [ADDR_W-1:0] BASE_ADDR  = 8'h10;
	localparam int                TX_DEPTH   = 2;
	localparam int                RX_DEPTH   = 2;
	localparam int                LC_CREDITS = 2;
	localparam int                SLEEP_NODE = 2;
	localparam int                HOLD_NODE  = 1;
	localparam int                RES_LAT    = NUM_NODES + FRAME_BITS + 1;
	localparam int                MAX_CYCLES = 40 * (FRAME_BITS + NUM_NODES + 8);

	logic                        clkin;
	logic                        rst_n;
	logic                        tx_valid;
	logic [ADDR_W-1:0]           tx_addr;
	logic [DATA_W-1:0]           tx_data;
	logic                        tx_credit;
	logic                        tx_succ;
	logic                        tx_fail;
	logic [NUM_NODES-1:0]        rx_valid;
	logic [NUM_NODES*DATA_W-1:0] rx_data;
	logic [NUM_NODES-1:0]        rx_bcast;
	logic [NUM_NODES-1:0]        rx_credit = '0;
	logic [NUM_NODES-1:0]        lc_sleep;
	logic [NUM_NODES-1:0]        lc_power_on;
	logic [NUM_NODES-1:0]        lc_release_clk;
	logic [NUM_NODES-1:0]        lc_release_rst;
	logic [NUM_NODES-1:0]        lc_release_iso;

	// scoreboards and reference model state
	logic [DATA_W:0]      exp_rx [NUM_NODES][$];
	bit                   res_q [$];
	int                   launch_q [$];
	int                   accepted [NUM_NODES] = '{default: 0};
	int                   credits_back [NUM_NODES] = '{default: 0};
	int                   credit_owed [NUM_NODES] = '{default: 0};
	int                   seen_cnt [NUM_NODES] = '{default: 0};
	bit                   asleep_model [NUM_NODES] = '{default: 0};
	logic [NUM_NODES-1:0] auto_credit = '1;
	int                   host_credits = TX_DEPTH;
	int                   credit_pulses = 0;
	int                   sent_total = 0;
	int                   results_seen = 0;
	int                   cycle = 0;
	int                   checks = 0;
	int                   errors = 0;
	int                   tests = 0;
	int                   test_err0 = 0;
	string                test_name = "none";
	int                   rise_cyc [4];
	logic [3:0]           last_pwr = 4'hf;

	mbus_ring_top #(
		.NUM_NODES  (NUM_NODES),
		.BASE_ADDR  (BASE_ADDR),
		.TX_DEPTH   (TX_DEPTH),
		.RX_DEPTH   (RX_DEPTH),
		.LC_CREDITS (LC_CREDITS)
	) dut (
		.clkin          (clkin),
		.rst_n          (rst_n),
		.tx_valid       (tx_valid),
		.tx_addr        (tx_addr),
		.tx_data        (tx_data),
		.tx_credit      (tx_credit),
		.tx_succ        (tx_succ),
		.tx_fail        (tx_fail),
		.rx_valid       (rx_valid),
		.rx_data        (rx_data),
		.rx_bcast       (rx_bcast),
		.rx_credit      (rx_credit),
		.lc_sleep       (lc_sleep),
		.lc_power_on    (lc_power_on),
		.lc_release_clk (lc_release_clk),
		.lc_release_rst (lc_release_rst),
		.lc_release_iso (lc_release_iso)
	);

	initial
	begin
		clkin = 1'b0;
		forever #4 clkin = ~clkin;
	end

	function automatic void report_error(input string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endfunction

	function automatic void check_eq(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
		end
	endfunction

	// words a member still holds, given the credits its layer has handed back
	function automatic int held_words(input int m);
		int granted;
		granted = LC_CREDITS + credits_back[m];
		return (accepted[m] > granted) ? accepted[m] - granted : 0;
	endfunction

	// apply the acknowledge rule to every member and book the expectations
	function automatic void predict_frame(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		bit any;
		bit uni;
		bit bc;
		any = 1'b0;
		bc  = (a == BCAST_ADDR);
		for (int m = 0; m < NUM_NODES; m++)
		begin
			uni = (a == ADDR_W'(BASE_ADDR + m));
			if ((uni || bc) && !asleep_model[m] && held_words(m) < RX_DEPTH)
			begin
				accepted[m]++;
				exp_rx[m].push_back({bc, d});
				any = 1'b1;
			end
			else if (uni && asleep_model[m])
				asleep_model[m] = 1'b0;
		end
		res_q.push_back(any);
	endfunction

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %-12s done, %0d errors", test_name, errors - test_err0);
	endtask

	task automatic send_msg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		do
		begin
			@(posedge clkin);
			#1;
		end
		while (host_credits == 0);
		predict_frame(a, d);
		host_credits--;
		sent_total++;
		tx_valid = 1'b1;
		tx_addr  = a;
		tx_data  = d;
		@(posedge clkin);
		#1;
		tx_valid = 1'b0;
	endtask

	task automatic wait_results();
		int limit;
		int n;
		limit = (res_q.size() + 1) * (RES_LAT + NUM_NODES + 8);
		n = 0;
		while (res_q.size() != 0 && n < limit)
		begin
			@(posedge clkin);
			#1;
			n++;
		end
		if (res_q.size() != 0)
			report_error($sformatf("%0d frame results never arrived", res_q.size()));
	endtask

	task automatic wait_drain();
		bit owed;
		for (int n = 0; n < 16; n++)
		begin
			owed = 1'b0;
			for (int m = 0; m < NUM_NODES; m++)
				if (exp_rx[m].size() != held_words(m))
					owed = 1'b1;
			if (!owed)
				break;
			@(posedge clkin);
			#1;
		end
		for (int m = 0; m < NUM_NODES; m++)
			if (exp_rx[m].size() != held_words(m))
				report_error($sformatf("member %0d never delivered an expected word", m));
	endtask

	task automatic give_credit(input int m);
		credit_owed[m]++;
		while (credit_owed[m] != 0)
		begin
			@(posedge clkin);
			#1;
		end
	endtask

	// layer models
	always @(posedge clkin)
	begin
		logic [NUM_NODES-1:0] nxt;
		for (int m = 0; m < NUM_NODES; m++)
		begin
			nxt[m] = 1'b0;
			if (rst_n && auto_credit[m] && rx_valid[m])
				nxt[m] = 1'b1;
			else if (rst_n && credit_owed[m] != 0)
			begin
				nxt[m] = 1'b1;
				credit_owed[m]--;
			end
			if (nxt[m])
				credits_back[m]++;
		end
		#1;
		rx_credit = nxt;
	end

	// result, credit and delivery monitors
	always @(posedge clkin)
	begin
		bit exp_res;
		if (rst_n)
		begin
			if (tx_credit)
			begin
				host_credits++;
				credit_pulses++;
				launch_q.push_back(cycle);
			end
			if (tx_succ || tx_fail)
			begin
				results_seen++;
				if (res_q.size() == 0)
					report_error("a frame result came back with no frame outstanding");
				else
				begin
					exp_res = res_q.pop_front();
					check_eq("result", {exp_res, !exp_res}, {tx_succ, tx_fail});
				end
				if (launch_q.size() != 0)
					check_eq("result latency", RES_LAT, cycle - launch_q.pop_front());
			end
			for (int m = 0; m < NUM_NODES; m++)
			begin
				if (rx_valid[m])
				begin
					seen_cnt[m]++;
					if (exp_rx[m].size() == 0)
						report_error($sformatf("member %0d delivered a word nobody sent", m));
					else
						check_eq($sformatf("member %0d word", m), exp_rx[m].pop_front(),
							{rx_bcast[m], rx_data[m*DATA_W +: DATA_W]});
				end
			end
		end
	end

	// rise times of the sleeping member's power outputs
	always @(posedge clkin)
	begin
		logic [3:0] now_pwr;
		now_pwr = {lc_power_on[SLEEP_NODE], lc_release_clk[SLEEP_NODE],
			lc_release_rst[SLEEP_NODE], lc_release_iso[SLEEP_NODE]};
		for (int k = 0; k < 4; k++)
			if (now_pwr[k] && !last_pwr[k])
				rise_cyc[k] = cycle;
		last_pwr = now_pwr;
	end

	assert property (@(posedge clkin) disable iff (!rst_n) !(tx_succ && tx_fail))
	else
		report_error("tx_succ and tx_fail were high in the same cycle");

	assert property (@(posedge clkin) disable iff (!rst_n)
		(tx_succ || tx_fail) |-> $past(tx_credit, RES_LAT))
	else
		report_error("a frame result came without a launch at the fixed latency");

	always @(posedge clkin)
	begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	initial
	begin
		int base;
		void'($urandom(32'hcc745241));
		rst_n    = 1'b0;
		tx_valid = 1'b0;
		tx_addr  = '0;
		tx_data  = '0;
		lc_sleep = '0;
		repeat (3) @(posedge clkin);
		#1;
		rst_n = 1'b1;
		@(posedge clkin);
		#1;

		start_test("reset");
		check_eq("idle outputs", 0, {tx_credit, tx_succ, tx_fail, rx_valid, dut.ring_free});
		check_eq("power outputs", {4*NUM_NODES{1'b1}},
			{lc_power_on, lc_release_clk, lc_release_rst, lc_release_iso});
		end_test();

		start_test("unicast");
		for (int m = 0; m < NUM_NODES; m++)
		begin
			send_msg(ADDR_W'(BASE_ADDR + m), $urandom);
			wait_results();
			wait_drain();
		end
		end_test();

		start_test("addr_miss");
		send_msg(8'h40, $urandom);
		wait_results();
		repeat (8) @(posedge clkin);
		#1;
		wait_drain();
		end_test();

		start_test("broadcast");
		send_msg(BCAST_ADDR, $urandom);
		wait_results();
		wait_drain();
		end_test();

		start_test("sleep_wake");
		lc_sleep[SLEEP_NODE] = 1'b1;
		@(posedge clkin);
		#1;
		lc_sleep[SLEEP_NODE] = 1'b0;
		asleep_model[SLEEP_NODE] = 1'b1;
		repeat (2) @(posedge clkin);
		#1;
		check_eq("power outputs asleep", 4'h0, last_pwr);
		rise_cyc = '{default: -1};
		tx_data = $urandom;
		base = tx_data;
		send_msg(ADDR_W'(BASE_ADDR + SLEEP_NODE), base);
		wait_results();
		repeat (4) @(posedge clkin);
		#1;
		check_eq("power outputs awake", 4'hf, last_pwr);
		check_eq("clock release cycle", rise_cyc[3] + 1, rise_cyc[2]);
		check_eq("reset release cycle", rise_cyc[2] + 1, rise_cyc[1]);
		check_eq("isolation release cycle", rise_cyc[1] + 1, rise_cyc[0]);
		send_msg(ADDR_W'(BASE_ADDR + SLEEP_NODE), base);
		wait_results();
		wait_drain();
		end_test();

		start_test("backpressure");
		auto_credit[HOLD_NODE] = 1'b0;
		base = seen_cnt[HOLD_NODE];
		for (int n = 0; n < LC_CREDITS + RX_DEPTH + 1; n++)
		begin
			send_msg(ADDR_W'(BASE_ADDR + HOLD_NODE), $urandom);
			wait_results();
		end
		wait_drain();
		check_eq("words delivered without credits", LC_CREDITS, seen_cnt[HOLD_NODE] - base);
		for (int k = 0; k < RX_DEPTH; k++)
		begin
			give_credit(HOLD_NODE);
			wait_drain();
			repeat (4) @(posedge clkin);
			#1;
			check_eq("words delivered after credit", LC_CREDITS + k + 1,
				seen_cnt[HOLD_NODE] - base);
		end
		// hand back what the layer consumed so it starts full again
		for (int k = 0; k < LC_CREDITS; k++)
			give_credit(HOLD_NODE);
		auto_credit[HOLD_NODE] = 1'b1;
		end_test();

		start_test("host_credits");
		send_msg(BASE_ADDR, $urandom);
		send_msg(ADDR_W'(BASE_ADDR + 3), $urandom);
		send_msg(8'h7e, $urandom);
		send_msg(BCAST_ADDR, $urandom);
		send_msg(ADDR_W'(BASE_ADDR + 1), $urandom);
		send_msg(ADDR_W'(BASE_ADDR + 2), $urandom);
		wait_results();
		wait_drain();
		repeat (4) @(posedge clkin);
		#1;
		check_eq("tx_credit pulses", sent_total, credit_pulses);
		check_eq("frame results", sent_total, results_seen);
		check_eq("host credits held", TX_DEPTH, host_credits);
		end_test();

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: compile.f
source/mbus_pkg.sv
source/mbus_frame_tx.sv
source/mbus_frame_snoop.sv
source/mbus_sleep_ctrl.sv
source/mbus_rx_buffer.sv
source/mbus_member_layer.sv
source/mbus_frame_sink.sv
source/mbus_ring_top.sv
tb/mbus_ring_tb.sv
